/* Makefile */
# Verilator simulation of the frame builder testbench

TOP             ?= frame_builder_tb
FILELIST        ?= tiny_tape_station.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the run passes only if the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* design/entity_detector.sv */
`default_nettype none

module entity_detector
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire frame_pkg::scan_pos_t scan,
    input  wire frame_pkg::entity_t   entities [frame_pkg::NUM_ENTITIES],
    output frame_pkg::entity_hit_t    hit
);
    import frame_pkg::*;

    logic [CNT_W-1:0]        org_h [NUM_ENTITIES];
    logic [CNT_W-1:0]        org_v [NUM_ENTITIES];
    logic [NUM_ENTITIES-1:0] match;
    logic [SLOT_W-1:0]       win;
    logic                    win_hit;
    logic [CNT_W-1:0]        dx;
    logic [CNT_W-1:0]        dy;

    // screen origin of each slot's tile and whether the scan point lies in its square
    always_comb
    begin
        for (int i = 0; i < NUM_ENTITIES; i++)
        begin
            org_h[i] = CNT_W'(entities[i].loc % TILES_H) * CNT_W'(TILE_PIX);
            org_v[i] = CNT_W'(entities[i].loc / TILES_H) * CNT_W'(TILE_PIX);
            // empty slots and locations past the last tile never match
            match[i] = (entities[i].id != EMPTY_ID)
                    && (entities[i].loc < NUM_TILES)
                    && (scan.h >= org_h[i])
                    && ((scan.h - org_h[i]) < CNT_W'(TILE_PIX))
                    && (scan.v >= org_v[i])
                    && ((scan.v - org_v[i]) < CNT_W'(TILE_PIX));
        end
    end

    // fixed priority, walk from the top slot down so the lowest match is left in win
    always_comb
    begin
        win     = '0;
        win_hit = 1'b0;
        for (int i = NUM_ENTITIES - 1; i >= 0; i--)
        begin
            if (match[i])
            begin
                win     = SLOT_W'(i);
                win_hit = 1'b1;
            end
        end
    end

    // offset inside the winning tile, only meaningful when win_hit is set
    assign dx = scan.h - org_h[win];
    assign dy = scan.v - org_v[win];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit.valid  <= 1'b0;
            hit.id     <= EMPTY_ID;
            hit.orient <= '0;
            hit.row    <= '0;
            hit.col    <= '0;
            hit.de     <= 1'b0;
            hit.hsync  <= 1'b1;
            hit.vsync  <= 1'b1;
        end
        else
        begin
            hit.valid  <= win_hit;
            hit.id     <= entities[win].id;
            hit.orient <= entities[win].orient;
            // 40 screen pixels fold down to 8 pattern pixels
            hit.row    <= 3'(dy / UPSCALE);
            hit.col    <= 3'(dx / UPSCALE);
            hit.de     <= scan.de;
            hit.hsync  <= scan.hsync;
            hit.vsync  <= scan.vsync;
        end
    end

endmodule

`default_nettype wire

/* design/frame_builder.sv */
`default_nettype none

module frame_builder
(
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             wb_cyc,
    input  wire                             wb_stb,
    input  wire                             wb_we,
    input  wire  [frame_pkg::WB_ADDR_W-1:0] wb_adr,
    input  wire  [frame_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic [frame_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                            wb_ack,
    output frame_pkg::pixel_t               rgb,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            de
);
    import frame_pkg::*;

    scan_pos_t   scan;
    entity_t     entities [NUM_ENTITIES];
    frame_ctrl_t ctrl;
    pattern_wr_t pattern_wr;
    entity_hit_t hit;

    // the pixel clock also runs the host port, so no crossing is needed
    scan_timing u_scan_timing
    (
        .clk    (clk),
        .arst_n (arst_n),
        .scan   (scan)
    );

    frame_config u_frame_config
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .entities   (entities),
        .ctrl       (ctrl),
        .pattern_wr (pattern_wr)
    );

    // first pipeline stage, which slot covers the pixel
    entity_detector u_entity_detector
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .scan     (scan),
        .entities (entities),
        .hit      (hit)
    );

    // second stage, pattern lookup and colour, two cycles after the counters
    tile_pattern_store u_tile_pattern_store
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .hit        (hit),
        .ctrl       (ctrl),
        .pattern_wr (pattern_wr),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de)
    );

endmodule

`default_nettype wire

/* design/frame_config.sv */
`default_nettype none

module frame_config
(
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               wb_cyc,
    input  wire                               wb_stb,
    input  wire                               wb_we,
    input  wire  [frame_pkg::WB_ADDR_W-1:0]   wb_adr,
    input  wire  [frame_pkg::WB_DATA_W-1:0]   wb_dat_w,
    output logic [frame_pkg::WB_DATA_W-1:0]   wb_dat_r,
    output logic                              wb_ack,
    output frame_pkg::entity_t                entities [frame_pkg::NUM_ENTITIES],
    output frame_pkg::frame_ctrl_t            ctrl,
    output frame_pkg::pattern_wr_t            pattern_wr
);
    import frame_pkg::*;

    logic                  req;
    logic                  served;
    logic                  accept;
    logic                  wr_en;
    logic                  is_entity;
    logic                  is_ctrl;
    logic                  is_pattern;
    logic [SLOT_W-1:0]     slot;
    logic [PAT_ADDR_W-1:0] pat_off;
    logic [WB_DATA_W-1:0]  rd_data;
    logic                  pat_stb;
    logic [3:0]            pat_id;
    logic [2:0]            pat_row;
    logic [TILE_SIZE-1:0]  pat_bits;

    // a request is taken once, then ignored until the master drops stb
    assign req    = wb_cyc && wb_stb;
    assign accept = req && !served;
    assign wr_en  = accept && wb_we;

    // address decode for the three regions
    assign is_entity  = wb_adr < WB_ADDR_W'(NUM_ENTITIES);
    assign is_ctrl    = wb_adr == WB_ADDR_W'(ADDR_CTRL);
    assign is_pattern = (wb_adr >= WB_ADDR_W'(PATTERN_BASE)) && (wb_adr < WB_ADDR_W'(PATTERN_END));
    assign slot       = wb_adr[SLOT_W-1:0];
    // upper four offset bits pick the id, the low three the pattern row
    assign pat_off    = PAT_ADDR_W'(wb_adr - WB_ADDR_W'(PATTERN_BASE));

    // the pattern region is write-only and reads back as zero, like unmapped space
    always_comb
    begin
        rd_data = '0;
        if (is_entity)
        begin
            rd_data[$bits(entity_t)-1:0] = entities[slot];
        end
        else if (is_ctrl)
        begin
            rd_data[$bits(frame_ctrl_t)-1:0] = ctrl;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack <= 1'b0;
            served <= 1'b0;
        end
        else
        begin
            wb_ack <= accept;
            if (!req)
            begin
                served <= 1'b0;
            end
            else if (accept)
            begin
                served <= 1'b1;
            end
        end
    end

    // read data is captured on the accepting edge and held for the ack cycle
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wb_dat_r <= rd_data;
        end
    end

    // register writes land on the same edge that raises ack
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_ENTITIES; i++)
            begin
                entities[i] <= EMPTY_ENTITY;
            end
            ctrl <= '0;
        end
        else if (wr_en)
        begin
            if (is_entity)
            begin
                entities[slot] <= wb_dat_w[$bits(entity_t)-1:0];
            end
            else if (is_ctrl)
            begin
                ctrl <= wb_dat_w[$bits(frame_ctrl_t)-1:0];
            end
        end
    end

    // pattern writes go out as a one-cycle strobe to the pattern memory
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pat_stb <= 1'b0;
        end
        else
        begin
            pat_stb <= wr_en && is_pattern;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en && is_pattern)
        begin
            pat_id   <= pat_off[6:3];
            pat_row  <= pat_off[2:0];
            pat_bits <= wb_dat_w[TILE_SIZE-1:0];
        end
    end

    assign pattern_wr = '{stb: pat_stb, id: pat_id, row: pat_row, bits: pat_bits};

endmodule

`default_nettype wire

/* design/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    // one tile is an 8x8 pattern, each pattern pixel drawn as a 5x5 block on screen
    localparam int TILE_SIZE    = 8;
    localparam int UPSCALE      = 5;
    localparam int TILE_PIX     = TILE_SIZE * UPSCALE;
    localparam int TILES_H      = 16;
    localparam int TILES_V      = 12;
    localparam int NUM_TILES    = TILES_H * TILES_V;
    localparam int NUM_ENTITIES = 9;
    localparam int SLOT_W       = $clog2(NUM_ENTITIES);
    localparam logic [3:0] EMPTY_ID = 4'hf;

    // 640x480 at 60 Hz, sync pulses are active low
    localparam int CNT_W        = 10;
    localparam int H_ACTIVE     = 640;
    localparam int H_FRONT      = 16;
    localparam int H_SYNC       = 96;
    localparam int H_BACK       = 48;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_ACTIVE     = 480;
    localparam int V_FRONT      = 10;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 33;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    // host register map, entity slots live at 0x00 up to NUM_ENTITIES-1
    localparam int WB_ADDR_W    = 8;
    localparam int WB_DATA_W    = 16;
    localparam int ADDR_CTRL    = 'h09;
    localparam int PATTERN_BASE = 'h40;
    // one pattern row per address, 16 ids of 8 rows each
    localparam int PATTERN_ROWS = 16 * TILE_SIZE;
    localparam int PATTERN_END  = PATTERN_BASE + PATTERN_ROWS;
    localparam int PAT_ADDR_W   = $clog2(PATTERN_ROWS);

    // colour word, two bits each of red, green and blue
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } pixel_t;

    // orient codes are 0 normal, 1 mirrored left-right, 2 flipped top-bottom, 3 both
    typedef struct packed {
        logic [3:0] id;
        logic [1:0] orient;
        logic [7:0] loc;
    } entity_t;

    localparam entity_t EMPTY_ENTITY = '{id: EMPTY_ID, orient: 2'd0, loc: 8'd0};

    typedef struct packed {
        logic   enable;
        pixel_t bg;
        pixel_t fg;
    } frame_ctrl_t;

    // bit 7 of a pattern row is the leftmost pattern pixel
    typedef struct packed {
        logic       stb;
        logic [3:0] id;
        logic [2:0] row;
        logic [7:0] bits;
    } pattern_wr_t;

    typedef struct packed {
        logic [CNT_W-1:0] h;
        logic [CNT_W-1:0] v;
        logic             de;
        logic             hsync;
        logic             vsync;
    } scan_pos_t;

    // row and col are pattern coordinates inside the tile, before orientation
    typedef struct packed {
        logic       valid;
        logic [3:0] id;
        logic [1:0] orient;
        logic [2:0] row;
        logic [2:0] col;
        logic       de;
        logic       hsync;
        logic       vsync;
    } entity_hit_t;

endpackage

`default_nettype wire

/* design/scan_timing.sv */
`default_nettype none

module scan_timing
(
    input  wire                  clk,
    input  wire                  arst_n,
    output frame_pkg::scan_pos_t scan
);
    import frame_pkg::*;

    logic [CNT_W-1:0] h_next;
    logic [CNT_W-1:0] v_next;
    logic             de_next;
    logic             hsync_next;
    logic             vsync_next;

    // next counter position, the line counter steps only when the pixel counter wraps
    always_comb
    begin
        h_next = scan.h + 1'b1;
        v_next = scan.v;
        if (scan.h == CNT_W'(H_TOTAL - 1))
        begin
            h_next = '0;
            if (scan.v == CNT_W'(V_TOTAL - 1))
            begin
                v_next = '0;
            end
            else
            begin
                v_next = scan.v + 1'b1;
            end
        end
    end

    // the flags are worked out for the next position so they land together with it
    always_comb
    begin
        de_next    = (h_next < CNT_W'(H_ACTIVE)) && (v_next < CNT_W'(V_ACTIVE));
        hsync_next = !((h_next >= CNT_W'(H_SYNC_START)) && (h_next < CNT_W'(H_SYNC_END)));
        vsync_next = !((v_next >= CNT_W'(V_SYNC_START)) && (v_next < CNT_W'(V_SYNC_END)));
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // syncs idle high, nothing visible until the first count
            scan.h     <= '0;
            scan.v     <= '0;
            scan.de    <= 1'b0;
            scan.hsync <= 1'b1;
            scan.vsync <= 1'b1;
        end
        else
        begin
            scan.h     <= h_next;
            scan.v     <= v_next;
            scan.de    <= de_next;
            scan.hsync <= hsync_next;
            scan.vsync <= vsync_next;
        end
    end

endmodule

`default_nettype wire

/* design/tile_pattern_store.sv */
`default_nettype none

module tile_pattern_store
(
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire frame_pkg::entity_hit_t hit,
    input  wire frame_pkg::frame_ctrl_t ctrl,
    input  wire frame_pkg::pattern_wr_t pattern_wr,
    output frame_pkg::pixel_t           rgb,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        de
);
    import frame_pkg::*;

    logic [TILE_SIZE-1:0] pattern_mem [PATTERN_ROWS];
    logic [2:0]           src_row;
    logic [2:0]           src_col;
    logic [TILE_SIZE-1:0] row_bits;
    logic                 pix_on;
    pixel_t               colour;

    // one row per address, indexed by id then pattern row
    always_ff @(posedge clk)
    begin
        if (pattern_wr.stb)
        begin
            pattern_mem[{pattern_wr.id, pattern_wr.row}] <= pattern_wr.bits;
        end
    end

    // orient bit 0 mirrors the columns, bit 1 flips the rows
    assign src_col = hit.orient[0] ? ~hit.col : hit.col;
    assign src_row = hit.orient[1] ? ~hit.row : hit.row;

    assign row_bits = pattern_mem[{hit.id, src_row}];
    // column 0 sits at the msb of the stored row
    assign pix_on   = row_bits[3'(TILE_SIZE - 1) - src_col];

    always_comb
    begin
        if (!ctrl.enable)
        begin
            colour = '0;
        end
        else if (hit.valid && pix_on)
        begin
            colour = ctrl.fg;
        end
        else
        begin
            colour = ctrl.bg;
        end
        // blanking always drives black
        if (!hit.de)
        begin
            colour = '0;
        end
    end

    // syncs take the same register stage as the pixel so they stay aligned
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rgb   <= '0;
            de    <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            rgb   <= colour;
            de    <= hit.de;
            hsync <= hit.hsync;
            vsync <= hit.vsync;
        end
    end

endmodule

`default_nettype wire

/* testbench/frame_builder_tb.sv */
`default_nettype none

module frame_builder_tb;
    import frame_pkg::*;

    localparam int WB_TIMEOUT    = 20;
    localparam int FRAME_TIMEOUT = H_TOTAL * V_TOTAL + 1000;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    pixel_t               rgb;
    logic                 hsync;
    logic                 vsync;
    logic                 de;

    // reference copy of everything the host has written so far
    entity_t              model_ent [NUM_ENTITIES];
    frame_ctrl_t          model_ctrl;
    logic [7:0]           model_pat [PATTERN_ROWS];

    logic [31:0]          rng_state = 32'd32063;
    int                   errors = 0;
    int                   checks = 0;

    frame_builder uut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de)
    );

    always #5 clk = ~clk;

    // plain LCG step whose upper half of the state has the better spread
    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    // expected colour of screen pixel (x, y) as given by the tile rules
    function automatic pixel_t model_pixel(input int x, input int y);
        int         tx;
        int         ty;
        int         col;
        int         row;
        logic [7:0] bits;
        if (!model_ctrl.enable)
        begin
            return '0;
        end
        // slots are scanned from 0 up, so the first hit is the winner
        for (int s = 0; s < NUM_ENTITIES; s++)
        begin
            tx = (int'(model_ent[s].loc) % TILES_H) * TILE_PIX;
            ty = (int'(model_ent[s].loc) / TILES_H) * TILE_PIX;
            if ((model_ent[s].id != EMPTY_ID) && (int'(model_ent[s].loc) < NUM_TILES)
                && (x >= tx) && (x < tx + TILE_PIX) && (y >= ty) && (y < ty + TILE_PIX))
            begin
                col = (x - tx) / UPSCALE;
                row = (y - ty) / UPSCALE;
                if (model_ent[s].orient[0])
                begin
                    col = TILE_SIZE - 1 - col;
                end
                if (model_ent[s].orient[1])
                begin
                    row = TILE_SIZE - 1 - row;
                end
                bits = model_pat[int'(model_ent[s].id) * TILE_SIZE + row];
                // the leftmost pattern pixel is bit 7
                return bits[TILE_SIZE - 1 - col] ? model_ctrl.fg : model_ctrl.bg;
            end
        end
        return model_ctrl.bg;
    endfunction

    task automatic expect_equal(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        end
    endtask

    // one classic cycle that starts a small delay after a rising edge
    task automatic wb_access(input logic we, input logic hold,
                             input logic [WB_ADDR_W-1:0] addr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        do
        begin
            @(posedge clk);
            #1;
            n++;
        end
        while (!wb_ack && n < WB_TIMEOUT);
        checks++;
        assert (wb_ack)
        else
        begin
            errors++;
            $display("ERROR t=%0t no acknowledge from the slave for address 0x%02h", $time, addr);
        end
        // ack must come on the clock right after the request appears
        expect_equal("wb_ack latency", 16'(1), 16'(n));
        rdata = wb_dat_r;
        if (hold)
        begin
            // the request stays up through the ack cycle and must not be answered again
            @(posedge clk);
            #1;
            expect_equal("wb_ack with stb held", 16'(0), 16'(wb_ack));
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        // exactly one ack cycle per access
        expect_equal("wb_ack", 16'(0), 16'(wb_ack));
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] unused;
        wb_access(1'b1, 1'b0, addr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] addr, output logic [WB_DATA_W-1:0] data);
        wb_access(1'b0, 1'b0, addr, '0, data);
    endtask

    task automatic read_expect(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] exp);
        logic [WB_DATA_W-1:0] data;
        wb_read(addr, data);
        expect_equal($sformatf("wb_dat_r[0x%02h]", addr), exp, data);
    endtask

    task automatic write_entity(input int slot, input logic [3:0] id, input logic [1:0] orient,
                                input logic [7:0] loc);
        entity_t e;
        e.id     = id;
        e.orient = orient;
        e.loc    = loc;
        wb_write(WB_ADDR_W'(slot), 16'(e));
        model_ent[slot] = e;
    endtask

    task automatic write_ctrl(input logic enable, input pixel_t bg, input pixel_t fg);
        frame_ctrl_t c;
        c.enable = enable;
        c.bg     = bg;
        c.fg     = fg;
        wb_write(WB_ADDR_W'(ADDR_CTRL), 16'(c));
        model_ctrl = c;
    endtask

    task automatic write_pattern(input int id, input int row, input logic [7:0] bits);
        wb_write(WB_ADDR_W'(PATTERN_BASE + id * TILE_SIZE + row), {8'h00, bits});
        model_pat[id * TILE_SIZE + row] = bits;
    endtask

    task automatic clear_entities();
        for (int i = 0; i < NUM_ENTITIES; i++)
        begin
            write_entity(i, EMPTY_ID, 2'd0, 8'd0);
        end
    endtask

    // returns just after the falling edge of vsync at the outputs
    task automatic wait_frame_start();
        int   n;
        logic prev;
        logic found;
        n     = 0;
        prev  = vsync;
        found = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
            found = prev && !vsync;
            prev  = vsync;
        end
        while (!found && n < FRAME_TIMEOUT);
        checks++;
        assert (found)
        else
        begin
            errors++;
            $display("ERROR t=%0t vsync never went low within one frame time", $time);
        end
    endtask

    // x and y come only from the de output and start at the first active line
    task automatic check_frame(input string label);
        int     n;
        int     x;
        int     y;
        logic   prev_de;
        logic   exp_hs;
        logic   exp_vs;
        pixel_t exp;
        n       = 0;
        x       = 0;
        y       = 0;
        prev_de = 1'b0;
        while (y < V_ACTIVE && n < FRAME_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
            // the call follows the vsync edge, so n counts clocks from the start of line 490
            exp_hs = !(((n % H_TOTAL) >= H_SYNC_START) && ((n % H_TOTAL) < H_SYNC_END));
            exp_vs = n >= V_SYNC * H_TOTAL;
            expect_equal("hsync", 16'(exp_hs), 16'(hsync));
            expect_equal("vsync", 16'(exp_vs), 16'(vsync));
            if (de && !prev_de && y == 0)
            begin
                expect_equal("clocks from vsync to first active pixel",
                             16'((V_TOTAL - V_SYNC_START) * H_TOTAL), 16'(n));
            end
            if (de)
            begin
                exp = model_pixel(x, y);
                checks++;
                assert (rgb === exp)
                else
                begin
                    errors++;
                    $display("FAIL t=%0t rgb at (%0d,%0d) expected 0x%02h got 0x%02h",
                             $time, x, y, exp, rgb);
                end
                x++;
            end
            else
            begin
                // blanking is always black
                checks++;
                assert (rgb === '0)
                else
                begin
                    errors++;
                    $display("FAIL t=%0t rgb in blanking expected 0x00 got 0x%02h", $time, rgb);
                end
                if (prev_de)
                begin
                    expect_equal("de active length", 16'(H_ACTIVE), 16'(x));
                    x = 0;
                    y++;
                end
            end
            prev_de = de;
        end
        checks++;
        assert (y == V_ACTIVE)
        else
        begin
            errors++;
            $display("ERROR t=%0t frame '%s' timed out after %0d lines", $time, label, y);
        end
        $display("frame '%s' checked", label);
    endtask

    task automatic after_reset();
        expect_equal("wb_ack", 16'(0), 16'(wb_ack));
        expect_equal("rgb", 16'(0), 16'(rgb));
        expect_equal("de", 16'(0), 16'(de));
        expect_equal("hsync", 16'(1), 16'(hsync));
        expect_equal("vsync", 16'(1), 16'(vsync));
        // every slot starts empty, which is id 4'hf in bits 13 to 10
        for (int i = 0; i < NUM_ENTITIES; i++)
        begin
            read_expect(WB_ADDR_W'(i), 16'h3c00);
        end
        read_expect(WB_ADDR_W'(ADDR_CTRL), 16'h0000);
        wait_frame_start();
        check_frame("after reset");
    endtask

    task automatic register_access();
        logic [15:0] value;
        logic [15:0] held;
        logic [15:0] unmapped [4];
        unmapped = '{16'h000a, 16'h003f, 16'h00c0, 16'h00ff};
        // the top bits are always sent as ones and must be dropped by the registers
        for (int i = 0; i < NUM_ENTITIES; i++)
        begin
            value = next_random() | 16'hc000;
            wb_write(WB_ADDR_W'(i), value);
            model_ent[i] = value[13:0];
            read_expect(WB_ADDR_W'(i), {2'b00, value[13:0]});
        end
        value = next_random() | 16'he000;
        wb_write(WB_ADDR_W'(ADDR_CTRL), value);
        model_ctrl = value[12:0];
        read_expect(WB_ADDR_W'(ADDR_CTRL), {3'b000, value[12:0]});
        // a read whose request is held past ack is still answered once
        wb_access(1'b0, 1'b1, WB_ADDR_W'(ADDR_CTRL), '0, held);
        expect_equal("wb_dat_r held read", {3'b000, value[12:0]}, held);
        // the pattern region is write-only
        write_pattern(0, 0, 8'ha5);
        read_expect(8'h40, 16'h0000);
        read_expect(8'h7f, 16'h0000);
        read_expect(8'hbf, 16'h0000);
        // unmapped writes are acknowledged and leave the registers alone
        for (int i = 0; i < 4; i++)
        begin
            wb_write(unmapped[i][7:0], 16'hffff);
            read_expect(unmapped[i][7:0], 16'h0000);
        end
        read_expect(WB_ADDR_W'(ADDR_CTRL), {3'b000, value[12:0]});
        read_expect(8'h00, 16'(model_ent[0]));
        clear_entities();
        write_ctrl(1'b0, '0, '0);
    endtask

    task automatic single_entity();
        logic [15:0] value;
        pixel_t      bg;
        for (int id = 0; id < 16; id++)
        begin
            for (int row = 0; row < TILE_SIZE; row++)
            begin
                value = next_random();
                write_pattern(id, row, value[7:0]);
            end
        end
        value = next_random();
        bg    = value[5:0];
        write_ctrl(1'b1, bg, ~bg);
        // bottom right tile, so both screen edges are covered
        write_entity(0, 4'd3, 2'd0, 8'hbf);
        wait_frame_start();
        check_frame("single entity");
    endtask

    task automatic orientation();
        logic [7:0] f_shape [TILE_SIZE];
        // an F shape differs under both mirror and flip
        f_shape = '{8'hfe, 8'h80, 8'h80, 8'hf8, 8'h80, 8'h80, 8'h80, 8'h00};
        for (int row = 0; row < TILE_SIZE; row++)
        begin
            write_pattern(5, row, f_shape[row]);
        end
        clear_entities();
        for (int i = 0; i < 4; i++)
        begin
            write_entity(i, 4'd5, 2'(i), 8'(8'h11 + 2 * i));
        end
        wait_frame_start();
        check_frame("orientation");
    endtask

    task automatic priority_and_exclusions();
        clear_entities();
        // slots 0 and 1 share a tile, slots 2 and 6 share another
        write_entity(0, 4'd1, 2'd0, 8'h44);
        write_entity(1, 4'd2, 2'd3, 8'h44);
        write_entity(2, 4'd9, 2'd1, 8'h52);
        write_entity(6, 4'd3, 2'd0, 8'h52);
        write_entity(5, 4'd7, 2'd2, 8'h0b);
        // an empty id on a visible tile and two locations past the last tile
        write_entity(3, EMPTY_ID, 2'd0, 8'h60);
        write_entity(4, 4'd6, 2'd0, 8'hc3);
        write_entity(8, 4'd8, 2'd0, 8'hff);
        wait_frame_start();
        check_frame("priority and exclusions");
    endtask

    task automatic display_disable();
        write_ctrl(1'b0, model_ctrl.bg, model_ctrl.fg);
        wait_frame_start();
        check_frame("display disabled");
        write_ctrl(1'b1, model_ctrl.bg, model_ctrl.fg);
        wait_frame_start();
        check_frame("display enabled again");
    endtask

    initial
    begin
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < NUM_ENTITIES; i++)
        begin
            model_ent[i] = EMPTY_ENTITY;
        end
        model_ctrl = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        after_reset();
        register_access();
        single_entity();
        orientation();
        priority_and_exclusions();
        display_disable();

        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        $finish;
    end

endmodule

`default_nettype wire

/* tiny_tape_station.f */
design/frame_pkg.sv
design/scan_timing.sv
design/frame_config.sv
design/entity_detector.sv
design/tile_pattern_store.sv
design/frame_builder.sv
testbench/frame_builder_tb.sv
